// ==== dispatch_control.sv ====
// Dispatcher: takes the queue head as the car target and drives motion, serve and door outputs
`timescale 1ns/1ps

module dispatch_control (
    input  logic                 clock,
    input  logic                 reset_n,
    input  elevator_pkg::floor_t current_floor,
    input  logic                 elevator_moving,
    input  logic                 door_open_btn,
    input  logic                 door_close_btn,
    request_if.dispatch          bus,
    output elevator_pkg::floor_t floor_selector,
    output logic                 direction_selector,
    output logic                 activate_elevator,
    output logic                 door_open_allowed,
    output logic                 door_close_allowed
);

    // Floor the car is currently heading for
    elevator_pkg::floor_t target;
    logic                 busy;
    logic                 take;
    logic                 arrive;
    logic                 serve_q;

    //////////////////////////////////////////////////////////////////////
    // Target selection and arrival
    //////////////////////////////////////////////////////////////////////

    // New target only while idle and the car is standing still
    assign take   = ~busy & ~elevator_moving & bus.head_valid & ~bus.halt;
    assign arrive = busy & ~elevator_moving & ~bus.halt & (target == current_floor);

    assign bus.pop = take;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target  <= elevator_pkg::floor_reset;
            busy    <= 1'b0;
            serve_q <= 1'b0;
        end else if (bus.power_off) begin
            target  <= elevator_pkg::floor_reset;
            busy    <= 1'b0;
            serve_q <= 1'b0;
        end else begin
            serve_q <= arrive;
            if (take) begin
                target <= bus.head_floor;
                busy   <= 1'b1;
            end else if (arrive) begin
                busy <= 1'b0;
            end
        end
    end

    // Target still holds the served floor during the serve cycle
    assign bus.serve       = serve_q;
    assign bus.serve_floor = target;

    //////////////////////////////////////////////////////////////////////
    // Motion and door outputs
    //////////////////////////////////////////////////////////////////////

    assign floor_selector     = target;
    assign direction_selector = target > current_floor;
    assign activate_elevator  = busy & ~bus.halt & (target != current_floor);

    // Doors only while the car is stopped and powered
    assign door_open_allowed  = door_open_btn & ~elevator_moving & ~bus.power_off;
    assign door_close_allowed = door_close_btn & ~elevator_moving & ~bus.power_off;

endmodule

// ==== elevator_pkg.sv ====
// Shared floor and queue definitions for the elevator request controller and its testbench

package elevator_pkg;

    //////////////////////////////////////////////////////////////////////
    // Building size
    //////////////////////////////////////////////////////////////////////

    // Floors are numbered from zero for the lowest floor
    localparam int floor_count = 11;

    // Floor number, wide enough for every floor
    typedef logic [3:0] floor_t;

    // One bit per floor for lights, buttons and pending sets
    typedef logic [floor_count-1:0] floor_mask_t;

    //////////////////////////////////////////////////////////////////////
    // Request queue sizing
    //////////////////////////////////////////////////////////////////////

    localparam int queue_depth  = 16;
    localparam int queue_addr_w = $clog2(queue_depth);

    // Read and write pointer, one extra wrap bit tells full from empty
    typedef logic [queue_addr_w:0] queue_ptr_t;

    //////////////////////////////////////////////////////////////////////
    // Reset values
    //////////////////////////////////////////////////////////////////////

    localparam floor_t      floor_reset = '0;
    localparam floor_mask_t mask_reset  = '0;
    localparam queue_ptr_t  ptr_reset   = '0;

endpackage

// ==== flist.f ====
elevator_pkg.sv
request_if.sv
request_capture.sv
request_queue.sv
dispatch_control.sv
floor_request_top.sv
tb_floor_request.sv

// ==== floor_request_top.sv ====
// Top level of the floor request controller, connects capture, queue and dispatch
`timescale 1ns/1ps

module floor_request_top (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      door_open_btn,
    input  logic                      door_close_btn,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      elevator_moving,
    output elevator_pkg::floor_t      floor_selector,
    output logic                      direction_selector,
    output logic                      activate_elevator,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    // Shared request signals between the three blocks
    request_if bus ();

    // Buttons in, lights out, new floors toward the queue
    request_capture request_capture_inst (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .bus                 (bus.capture),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    request_queue request_queue_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .bus     (bus.queue)
    );

    // Motion controller side
    dispatch_control dispatch_control_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .bus                (bus.dispatch),
        .floor_selector     (floor_selector),
        .direction_selector (direction_selector),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// ==== request_capture.sv ====
// Button capture: latches hall and car buttons into lights and feeds new floors to the queue
`timescale 1ns/1ps

module request_capture (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  elevator_pkg::floor_t      current_floor,
    request_if.capture                bus,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights
);

    // Floors lit but not yet handed to the queue
    elevator_pkg::floor_mask_t pending;

    elevator_pkg::floor_mask_t here_mask;
    elevator_pkg::floor_mask_t call_accept;
    elevator_pkg::floor_mask_t panel_accept;
    elevator_pkg::floor_mask_t new_mask;
    elevator_pkg::floor_mask_t push_mask;
    elevator_pkg::floor_mask_t serve_mask;
    logic                      power_off;
    logic                      halt;

    // Lowest set bit of a floor mask, floor zero when empty
    function automatic elevator_pkg::floor_t lowest_floor(input elevator_pkg::floor_mask_t m);
        elevator_pkg::floor_t f;
        f = elevator_pkg::floor_reset;
        for (int i = elevator_pkg::floor_count - 1; i >= 0; i--) begin
            if (m[i]) begin
                f = elevator_pkg::floor_t'(i);
            end
        end
        return f;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Power and emergency conditioning
    //////////////////////////////////////////////////////////////////////

    assign power_off     = ~power_switch;
    assign halt          = power_off | emergency_btn;
    assign bus.power_off = power_off;
    assign bus.halt      = halt;

    //////////////////////////////////////////////////////////////////////
    // Button acceptance
    //////////////////////////////////////////////////////////////////////

    // Pressing the floor the car is at does nothing
    assign here_mask    = elevator_pkg::floor_mask_t'(1) << current_floor;
    assign call_accept  = halt ? elevator_pkg::mask_reset :
                          (floor_call_buttons & ~call_button_lights & ~here_mask);
    assign panel_accept = halt ? elevator_pkg::mask_reset :
                          (panel_buttons & ~panel_button_lights & ~here_mask);

    // A floor is queued once per lighting, even if both buttons light it
    assign new_mask = (call_accept | panel_accept) &
                      ~(call_button_lights | panel_button_lights);

    // Hand the lowest pending floor to the queue unless it is full
    assign bus.push       = (|pending) & ~bus.full;
    assign bus.push_floor = lowest_floor(pending);
    assign push_mask      = bus.push ? (elevator_pkg::floor_mask_t'(1) << bus.push_floor) :
                                       elevator_pkg::mask_reset;
    assign serve_mask     = bus.serve ? (elevator_pkg::floor_mask_t'(1) << bus.serve_floor) :
                                        elevator_pkg::mask_reset;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= elevator_pkg::mask_reset;
            panel_button_lights <= elevator_pkg::mask_reset;
            pending             <= elevator_pkg::mask_reset;
        end else if (power_off) begin
            call_button_lights  <= elevator_pkg::mask_reset;
            panel_button_lights <= elevator_pkg::mask_reset;
            pending             <= elevator_pkg::mask_reset;
        end else begin
            call_button_lights  <= (call_button_lights & ~serve_mask) | call_accept;
            panel_button_lights <= (panel_button_lights & ~serve_mask) | panel_accept;
            pending             <= (pending & ~push_mask) | new_mask;
        end
    end

endmodule

// ==== request_if.sv ====
// Bundle of capture, queue and dispatch signals, instanced once in the top level
`timescale 1ns/1ps

interface request_if;

    // Capture to queue, new floor request strobe
    logic                 push;
    elevator_pkg::floor_t push_floor;

    // Power and emergency conditioning, levels
    logic                 power_off;
    logic                 halt;

    // Queue status and oldest entry
    logic                 full;
    logic                 head_valid;
    elevator_pkg::floor_t head_floor;

    // Dispatch strobes, take the head and clear a served floor
    logic                 pop;
    logic                 serve;
    elevator_pkg::floor_t serve_floor;

    modport capture  (output push, push_floor, power_off, halt,
                      input  full, serve, serve_floor);

    modport queue    (input  push, push_floor, pop, power_off,
                      output full, head_valid, head_floor);

    modport dispatch (input  head_valid, head_floor, halt, power_off,
                      output pop, serve, serve_floor);

endinterface

// ==== request_queue.sv ====
// Request FIFO: holds accepted floor numbers in arrival order for the dispatcher
`timescale 1ns/1ps

module request_queue (
    input  logic     clock,
    input  logic     reset_n,
    request_if.queue bus
);

    // Entry storage, written only through the write pointer
    elevator_pkg::floor_t mem [elevator_pkg::queue_depth];

    elevator_pkg::queue_ptr_t wr_ptr;
    elevator_pkg::queue_ptr_t rd_ptr;
    logic                     do_write;
    logic                     do_read;
    logic                     ptr_wrap_differs;
    logic                     ptr_addr_equal;

    //////////////////////////////////////////////////////////////////////
    // Status
    //////////////////////////////////////////////////////////////////////

    // Same address with opposite wrap bits means every slot is taken
    assign ptr_wrap_differs = wr_ptr[elevator_pkg::queue_addr_w] !=
                              rd_ptr[elevator_pkg::queue_addr_w];
    assign ptr_addr_equal   = wr_ptr[elevator_pkg::queue_addr_w-1:0] ==
                              rd_ptr[elevator_pkg::queue_addr_w-1:0];

    assign bus.full       = ptr_wrap_differs & ptr_addr_equal;
    assign bus.head_valid = (wr_ptr != rd_ptr);
    assign bus.head_floor = mem[rd_ptr[elevator_pkg::queue_addr_w-1:0]];

    assign do_write = bus.push & ~bus.full & ~bus.power_off;
    assign do_read  = bus.pop & bus.head_valid & ~bus.power_off;

    //////////////////////////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[elevator_pkg::queue_addr_w-1:0]] <= bus.push_floor;
        end
    end

    // Power off empties the queue at every edge it is held
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= elevator_pkg::ptr_reset;
            rd_ptr <= elevator_pkg::ptr_reset;
        end else if (bus.power_off) begin
            wr_ptr <= elevator_pkg::ptr_reset;
            rd_ptr <= elevator_pkg::ptr_reset;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== tb_floor_request.sv ====
// Directed testbench for the floor request controller, drives buttons and models the car
`timescale 1ns/1ps

module tb_floor_request;

    localparam int wait_limit  = 300;
    localparam int cond_active = 0;
    localparam int cond_moving = 1;
    localparam int cond_dark   = 2;

    logic                      clock;
    logic                      reset_n;
    elevator_pkg::floor_mask_t floor_call_buttons;
    elevator_pkg::floor_mask_t panel_buttons;
    logic                      door_open_btn;
    logic                      door_close_btn;
    logic                      emergency_btn;
    logic                      power_switch;
    elevator_pkg::floor_t      current_floor = '0;
    logic                      elevator_moving = 1'b0;
    elevator_pkg::floor_t      floor_selector;
    logic                      direction_selector;
    logic                      activate_elevator;
    elevator_pkg::floor_mask_t call_button_lights;
    elevator_pkg::floor_mask_t panel_button_lights;
    logic                      door_open_allowed;
    logic                      door_close_allowed;

    int                   errors = 0;
    int                   timeouts = 0;
    logic [15:0]          lfsr_state = 16'd41618;
    logic                 car_go;
    elevator_pkg::floor_t car_target;
    int                   step_count = 0;

    floor_request_top floor_request_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Car model
    //////////////////////////////////////////////////////////////////////

    // Samples the controller at the edge, then moves one floor every four cycles
    always @(posedge clock) begin
        car_go     = reset_n & activate_elevator;
        car_target = floor_selector;
        #1;
        if (!car_go) begin
            elevator_moving = 1'b0;
            step_count      = 0;
        end else begin
            elevator_moving = 1'b1;
            step_count      = step_count + 1;
            if (step_count == 4) begin
                step_count = 0;
                if (car_target > current_floor) begin
                    current_floor = current_floor + 1'b1;
                end else if (car_target < current_floor) begin
                    current_floor = current_floor - 1'b1;
                end
                if (current_floor == car_target) begin
                    elevator_moving = 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    function automatic elevator_pkg::floor_mask_t floor_bit(input elevator_pkg::floor_t f);
        return elevator_pkg::floor_mask_t'(1) << f;
    endfunction

    // Galois LFSR with maximal length taps for 16 bits
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Four LFSR bits give a floor, then it slides past the floors to avoid
    task automatic pick_floor(input elevator_pkg::floor_t a, input elevator_pkg::floor_t b,
                              input elevator_pkg::floor_t c, output elevator_pkg::floor_t f);
        logic [3:0] bits;
        int         v;
        bits = '0;
        for (int i = 0; i < 4; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[2:0], lfsr_state[0]};
        end
        v = bits % elevator_pkg::floor_count;
        for (int i = 0; i < 4; i++) begin
            if (v == a || v == b || v == c) begin
                v = (v + 1) % elevator_pkg::floor_count;
            end
        end
        f = elevator_pkg::floor_t'(v);
    endtask

    // Holds buttons for one cycle and returns after the edge that latches them
    task automatic press(input elevator_pkg::floor_mask_t call,
                         input elevator_pkg::floor_mask_t panel);
        next_cycle();
        floor_call_buttons = call;
        panel_buttons      = panel;
        next_cycle();
        floor_call_buttons = '0;
        panel_buttons      = '0;
        @(negedge clock);
    endtask

    // Polls at falling edges, where every output has settled
    task automatic poll_until(input int kind, input elevator_pkg::floor_t f, input string what);
        int cycles;
        bit met;
        cycles = 0;
        met    = 1'b0;
        while (!met && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
            case (kind)
                cond_active: met = activate_elevator === 1'b1;
                cond_moving: met = elevator_moving === 1'b1;
                default:     met = !call_button_lights[f] && !panel_button_lights[f];
            endcase
        end
        if (!met) begin
            timeouts++;
            $display("Timeout at %0t: gave up waiting for %s", $time, what);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        @(negedge clock);
        if (activate_elevator !== 1'b0 || direction_selector !== 1'b0) begin
            report_error("motion outputs not low after reset");
        end
        if (door_open_allowed !== 1'b0 || door_close_allowed !== 1'b0) begin
            report_error("door permits not low after reset");
        end
        if (call_button_lights !== '0 || panel_button_lights !== '0) begin
            report_error("lights not dark after reset");
        end
        if (floor_selector !== '0) begin
            report_error("floor_selector not floor zero after reset");
        end
    endtask

    task automatic single_request();
        elevator_pkg::floor_t f;
        elevator_pkg::floor_t start;
        start = current_floor;
        pick_floor(start, start, start, f);
        press('0, floor_bit(f));
        if (panel_button_lights !== floor_bit(f)) begin
            report_error($sformatf("panel light for floor %0d not set", f));
        end
        poll_until(cond_active, f, "activate on a single request");
        if (floor_selector !== f) begin
            report_error($sformatf("floor_selector %0d, requested %0d", floor_selector, f));
        end
        if (direction_selector !== (f > start)) begin
            report_error("direction_selector does not match the request");
        end
        poll_until(cond_dark, f, "lights to clear after a single request");
        if (current_floor !== f) begin
            report_error("lights cleared before the car arrived");
        end
        // A press at the floor where the car stands is ignored
        press(floor_bit(f), floor_bit(f));
        if (call_button_lights !== '0 || panel_button_lights !== '0) begin
            report_error("press at the current floor lit a light");
        end
    endtask

    task automatic queue_order();
        elevator_pkg::floor_t      fl [3];
        elevator_pkg::floor_mask_t req;
        elevator_pkg::floor_t      order [$];
        pick_floor(current_floor, current_floor, current_floor, fl[0]);
        pick_floor(current_floor, fl[0], fl[0], fl[1]);
        pick_floor(current_floor, fl[0], fl[1], fl[2]);
        press(floor_bit(fl[0]) | floor_bit(fl[2]), floor_bit(fl[1]) | floor_bit(fl[2]));
        if (call_button_lights !== (floor_bit(fl[0]) | floor_bit(fl[2])) ||
            panel_button_lights !== (floor_bit(fl[1]) | floor_bit(fl[2]))) begin
            report_error("lights wrong after three requests");
        end
        // Pending floors are pushed lowest first, so service runs upward
        req = floor_bit(fl[0]) | floor_bit(fl[1]) | floor_bit(fl[2]);
        for (int i = 0; i < elevator_pkg::floor_count; i++) begin
            if (req[i]) begin
                order.push_back(elevator_pkg::floor_t'(i));
            end
        end
        foreach (order[i]) begin
            poll_until(cond_active, order[i], "activate for a queued floor");
            if (floor_selector !== order[i]) begin
                report_error($sformatf("served %0d, expected %0d", floor_selector, order[i]));
            end
            if (direction_selector !== (order[i] > current_floor)) begin
                report_error($sformatf("direction_selector wrong toward floor %0d", order[i]));
            end
            poll_until(cond_dark, order[i], "queued floor lights to clear");
        end
    endtask

    task automatic emergency_hold();
        elevator_pkg::floor_t f;
        elevator_pkg::floor_t g;
        pick_floor(current_floor, current_floor, current_floor, f);
        pick_floor(current_floor, f, f, g);
        press('0, floor_bit(f));
        next_cycle();
        emergency_btn = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(negedge clock);
            if (activate_elevator !== 1'b0) begin
                report_error("activate_elevator high during emergency");
            end
        end
        press(floor_bit(g), '0);
        if (call_button_lights[g] !== 1'b0) begin
            report_error("press accepted during emergency");
        end
        if (panel_button_lights[f] !== 1'b1) begin
            report_error("lit request lost during emergency");
        end
        next_cycle();
        emergency_btn = 1'b0;
        poll_until(cond_active, f, "activate after emergency release");
        if (floor_selector !== f) begin
            report_error("wrong target after emergency release");
        end
        poll_until(cond_dark, f, "lights to clear after emergency release");
    endtask

    task automatic door_permits();
        elevator_pkg::floor_t f;
        next_cycle();
        door_open_btn  = 1'b1;
        door_close_btn = 1'b0;
        @(negedge clock);
        if (door_open_allowed !== 1'b1 || door_close_allowed !== 1'b0) begin
            report_error("door permits do not follow open button while stopped");
        end
        next_cycle();
        door_open_btn  = 1'b0;
        door_close_btn = 1'b1;
        @(negedge clock);
        if (door_open_allowed !== 1'b0 || door_close_allowed !== 1'b1) begin
            report_error("door permits do not follow close button while stopped");
        end
        pick_floor(current_floor, current_floor, current_floor, f);
        press('0, floor_bit(f));
        poll_until(cond_moving, f, "car to start moving");
        next_cycle();
        door_open_btn = 1'b1;
        @(negedge clock);
        if (door_open_allowed !== 1'b0 || door_close_allowed !== 1'b0) begin
            report_error("door permit given while moving");
        end
        poll_until(cond_dark, f, "lights to clear after door test trip");
        next_cycle();
        power_switch = 1'b0;
        @(negedge clock);
        if (door_open_allowed !== 1'b0 || door_close_allowed !== 1'b0) begin
            report_error("door permit given with power off");
        end
        next_cycle();
        power_switch   = 1'b1;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
    endtask

    task automatic power_drop();
        elevator_pkg::floor_t f;
        pick_floor(current_floor, current_floor, current_floor, f);
        press(floor_bit(f), floor_bit(f));
        poll_until(cond_active, f, "activate before power off");
        next_cycle();
        power_switch = 1'b0;
        @(negedge clock);
        if (activate_elevator !== 1'b0) begin
            report_error("activate_elevator high with power off");
        end
        @(negedge clock);
        if (call_button_lights !== '0 || panel_button_lights !== '0) begin
            report_error("lights not cleared by power off");
        end
        next_cycle();
        power_switch = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clock);
            if (activate_elevator !== 1'b0) begin
                report_error("activate_elevator rose after power returned");
            end
        end
    endtask

    initial begin
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        repeat (16) @(posedge clock);
        #1;
        reset_n = 1'b1;
        reset_state();
        single_request();
        queue_order();
        emergency_hold();
        door_permits();
        power_drop();
        $display("Finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
